// ==== all.f ====
src/rk_pkg.sv
src/rk_regs.sv
src/rk_sequencer.sv
src/ata_pio.sv
src/rk_ide_top.sv
bench/ide_disk_model.sv
bench/rk_ide_chk.sv
bench/tb_rk_ide.sv

// ==== bench/ide_disk_model.sv ====
/*
 * behavioral ide drive
 * task file, status, sector data store and a word pointer for pio transfers
 */
`timescale 1ns/1ns

module ide_disk_model (
   input  logic             clk,
   input  rk_pkg::ide_out_t ide,
   output logic [15:0]      data,
   output logic [12:0]      disk_index,
   input  logic [15:0]      fill_word,
   input  logic             inject_err
);
   import rk_pkg::*;

   logic [15:0] store [0:8191];
   logic        written [0:8191] = '{default: 1'b0};
   logic [7:0]  seccnt = 8'd0;
   logic [7:0]  secnum = 8'd0;
   logic [7:0]  cyllow = 8'd0;
   logic [7:0]  cylhigh = 8'd0;
   logic [15:0] command = 16'd0;
   logic        cmd_seen = 1'b0;
   logic [12:0] ptr = 13'd0;
   logic [15:0] left = 16'd0;
   logic        dior_q = 1'b0;
   logic        diow_q = 1'b0;
   logic [4:0]  addr_q = 5'd0;
   logic        err;
   logic [7:0]  status;

   assign err = inject_err && cmd_seen;
   assign status = {1'b0, 1'b1, 2'b00, (left != 16'd0) && !err, 2'b00, err};
   assign disk_index = ptr;

   // words never written come from the preload pattern
   always_comb
   begin
      case ({ide.cs, ide.da})
         ATA_REG_DATA: data = written[ptr] ? store[ptr] : fill_word;
         ATA_REG_STATUS, ATA_REG_ALTER: data = {8'd0, status};
         default: data = 16'd0;
      endcase
   end

   always @(posedge clk)
   begin
      dior_q <= ide.dior;
      diow_q <= ide.diow;
      addr_q <= {ide.cs, ide.da};
      // write data is only on the bus while the controller drives it
      if (ide.diow && !diow_q && ide.data_oe)
      begin
         case ({ide.cs, ide.da})
            ATA_REG_SECCNT: seccnt <= ide.data[7:0];
            ATA_REG_SECNUM: secnum <= ide.data[7:0];
            ATA_REG_CYLLOW: cyllow <= ide.data[7:0];
            ATA_REG_CYLHIGH: cylhigh <= ide.data[7:0];
            ATA_REG_COMMAND:
            begin
               command <= ide.data;
               cmd_seen <= 1'b1;
               // store holds 32 sectors, so the low lba bits pick the sector
               ptr <= {secnum[4:0], 8'd0};
               left <= {seccnt, 8'd0};
            end
            ATA_REG_DATA:
            begin
               store[ptr] <= ide.data;
               written[ptr] <= 1'b1;
               ptr <= ptr + 13'd1;
               left <= left - 16'd1;
            end
            default: ;
         endcase
      end
      // a data read is consumed when dior releases
      if (!ide.dior && dior_q && addr_q == ATA_REG_DATA)
      begin
         ptr <= ptr + 13'd1;
         left <= left - 16'd1;
      end
   end

endmodule

// ==== bench/rk_ide_chk.sv ====
/*
 * protocol assertions for the rk11 ide controller
 */
`timescale 1ns/1ns

module rk_ide_chk (
   input logic             clk,
   input logic             reset,
   input rk_pkg::ide_out_t ide_out,
   input rk_pkg::dma_out_t dma,
   input logic             dma_ack,
   input logic             interrupt,
   input logic             interrupt_ack
);

   strobe_excl: assert property (@(posedge clk) disable iff (reset)
      !(ide_out.dior && ide_out.diow))
      else $error("dior and diow high together");

   dma_handshake: assert property (@(posedge clk) disable iff (reset)
      (dma.rd || dma.wr) |-> (dma.req && dma_ack))
      else $error("dma transfer without req and ack");

   // held until the host acknowledges
   int_hold: assert property (@(posedge clk) disable iff (reset)
      (interrupt && !interrupt_ack) |=> interrupt)
      else $error("interrupt dropped without ack");

endmodule

bind rk_ide_top rk_ide_chk i_chk (
   .clk(clk), .reset(reset), .ide_out(ide_out), .dma(dma), .dma_ack(dma_ack),
   .interrupt(interrupt), .interrupt_ack(interrupt_ack)
);

// ==== bench/tb_rk_ide.sv ====
/*
 * rk11 ide controller testbench
 * host register tasks, dma memory, disk model and result checks
 */
`timescale 1ns/1ns

module tb_rk_ide;
   import rk_pkg::*;

   localparam int MAX_CYCLES = 20000;
   // da 'h0012 is track 1, sector 2
   localparam logic [15:0] READ_LBA = 16'd14;

   logic        clk = 1'b0;
   logic        reset = 1'b1;
   iopage_req_t iopage = '0;
   logic        interrupt_ack = 1'b0;
   logic        dma_ack = 1'b0;
   logic [15:0] dma_data_in = 16'd0;
   logic        inject_err = 1'b0;
   logic [15:0] data_out;
   logic        decode;
   logic        interrupt;
   dma_out_t    dma;
   ide_out_t    ide_out;
   logic [15:0] ide_data_in;
   logic [12:0] disk_index;
   logic [15:0] disk_fill;

   int seed = 32'h93e3;
   int ack_delay = 0;
   int cycles = 0;
   int errors = 0;
   int tests = 0;
   int int_count = 0;
   logic [15:0] mem [logic [17:0]];
   logic [17:0] wr_addr [$];
   logic [15:0] wr_data [$];

   rk_ide_top i_dut (
      .clk(clk), .reset(reset), .iopage(iopage), .data_out(data_out), .decode(decode),
      .interrupt(interrupt), .interrupt_ack(interrupt_ack), .dma(dma), .dma_ack(dma_ack),
      .dma_data_in(dma_data_in), .ide_out(ide_out), .ide_data_in(ide_data_in)
   );

   ide_disk_model i_disk (
      .clk(clk), .ide(ide_out), .data(ide_data_in), .disk_index(disk_index),
      .fill_word(disk_fill), .inject_err(inject_err)
   );

   // expected disk contents per lba and word
   function automatic logic [15:0] ref_word(input logic [15:0] lba, input logic [7:0] idx);
      return (lba * 16'h0101) ^ {idx, ~idx} ^ 16'h5a0f;
   endfunction

   function automatic logic [15:0] fill_word(input logic [17:0] a);
      return a[15:0] ^ {a[17:16], 14'h01a5};
   endfunction

   assign disk_fill = ref_word(16'(disk_index[12:8]), disk_index[7:0]);

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycles++;
      if (cycles == MAX_CYCLES)
      begin
         $display("timeout: no completion within %0d cycles", MAX_CYCLES);
         $display("tests failed");
         $finish;
      end
   end

   always @(negedge clk)
   begin
      if (interrupt)
         int_count++;
   end

   // memory side of the dma port, random ack delay
   always @(negedge clk)
   begin
      if (dma_ack)
      begin
         dma_ack = 1'b0;
         ack_delay = $random(seed) & 3;
      end
      else if (dma.req)
      begin
         if (ack_delay == 0)
         begin
            dma_ack = 1'b1;
            dma_data_in = mem.exists(dma.addr) ? mem[dma.addr] : fill_word(dma.addr);
            #1;
            if (dma.wr)
            begin
               mem[dma.addr] = dma.wdata;
               wr_addr.push_back(dma.addr);
               wr_data.push_back(dma.wdata);
            end
            else if (!dma.rd)
            begin
               $display("Fail %0t: dma ack with neither rd nor wr", $time);
               errors++;
            end
         end
         else
            ack_delay--;
      end
   end

   task automatic reg_write(input logic [12:0] addr, input logic [15:0] value);
      @(negedge clk);
      iopage.addr = addr;
      iopage.data = value;
      iopage.wr = 1'b1;
      @(negedge clk);
      iopage.wr = 1'b0;
   endtask

   task automatic reg_read(input logic [12:0] addr, output logic [15:0] value,
                           output logic dec);
      @(negedge clk);
      iopage.addr = addr;
      iopage.rd = 1'b1;
      #1;
      value = data_out;
      dec = decode;
      iopage.rd = 1'b0;
   endtask

   task automatic compare(input string what, input logic [17:0] got, input logic [17:0] exp);
      if (got !== exp)
      begin
         $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      if (errors == err_before)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d checks failed", name, errors - err_before);
   endtask

   task automatic run_cmd(input logic [2:0] fn, input logic ie, input logic [15:0] wc,
                          input logic [15:0] ba, input logic [15:0] da);
      logic [15:0] v;
      logic        d;
      reg_write(RK_ADDR_WC, wc);
      reg_write(RK_ADDR_BA, ba);
      reg_write(RK_ADDR_DA, da);
      reg_write(RK_ADDR_CS, (16'(ie) << CSR_IE) | (16'(fn) << CSR_FN) | 16'd1);
      do
         reg_read(RK_ADDR_CS, v, d);
      while (!v[CSR_DONE]);
   endtask

   // registers after a full transfer
   task automatic check_final(input logic [15:0] ba);
      logic [15:0] v;
      logic        d;
      reg_read(RK_ADDR_WC, v, d);
      compare("final wc", 18'(v), 18'd0);
      reg_read(RK_ADDR_BA, v, d);
      compare("final ba", 18'(v), 18'(ba + 16'd1024));
      reg_read(RK_ADDR_CS, v, d);
      compare("final csr", 18'(v & 16'h008f), 18'h00080);
   endtask

   initial
   begin
      logic [15:0] v;
      logic        d;
      int          e0;
      int          q0;
      int          ic;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      e0 = errors;
      reg_write(RK_ADDR_WC, 16'o177400);
      reg_write(RK_ADDR_BA, 16'o123456);
      reg_write(RK_ADDR_DA, 16'o000765);
      reg_read(RK_ADDR_WC, v, d);
      compare("wc", 18'(v), 18'o177400);
      reg_read(RK_ADDR_BA, v, d);
      compare("ba", 18'(v), 18'o123456);
      reg_read(RK_ADDR_DA, v, d);
      compare("da", 18'(v), 18'o000765);
      reg_write(RK_ADDR_CS, 16'h007a);
      reg_read(RK_ADDR_CS, v, d);
      compare("csr", 18'(v), 18'h0007a);
      reg_write(RK_ADDR_CS, 16'd0);
      reg_read(13'o17414, v, d);
      compare("unmapped decode", 18'(d), 18'd0);
      compare("unmapped data", 18'(v), 18'd0);
      end_test("registers", e0);

      e0 = errors;
      q0 = wr_addr.size();
      run_cmd(RK_FN_READ, 1'b0, 16'hfe00, 16'h2000, 16'h0012);
      compare("seccnt", 18'(i_disk.seccnt), 18'(16'(-16'hfe00) >> 8));
      compare("secnum", 18'(i_disk.secnum), 18'(READ_LBA & 16'h00ff));
      compare("cyllow", 18'(i_disk.cyllow), 18'(READ_LBA >> 8));
      compare("cylhigh", 18'(i_disk.cylhigh), 18'd0);
      compare("command", 18'(i_disk.command), 18'h00020);
      end_test("task file", e0);

      e0 = errors;
      compare("dma write count", 18'(wr_addr.size() - q0), 18'd512);
      for (int i = 0; i < 512 && q0 + i < wr_addr.size(); i++)
      begin
         compare("dma addr", wr_addr[q0 + i], 18'(32'h2000 + 2 * i));
         compare("dma data", 18'(wr_data[q0 + i]),
                 18'(ref_word(READ_LBA + 16'(i / 256), 8'(i % 256))));
      end
      check_final(16'h2000);
      end_test("two sector read", e0);

      e0 = errors;
      run_cmd(RK_FN_WRITE, 1'b0, 16'hfe00, 16'h4000, 16'h0005);
      for (int i = 0; i < 512; i++)
         compare("disk word", 18'(i_disk.store[5 * 256 + i]),
                 18'(fill_word(18'(32'h4000 + 2 * i))));
      check_final(16'h4000);
      end_test("two sector write", e0);

      e0 = errors;
      run_cmd(RK_FN_READ, 1'b1, 16'hff00, 16'h6000, 16'h0012);
      repeat (3) @(negedge clk);
      compare("interrupt before ack", 18'(interrupt), 18'd1);
      interrupt_ack = 1'b1;
      @(negedge clk);
      interrupt_ack = 1'b0;
      compare("interrupt after ack", 18'(interrupt), 18'd0);
      compare("vector", 18'(RK_VECTOR), 18'o220);
      ic = int_count;
      run_cmd(RK_FN_READ, 1'b0, 16'hff00, 16'h6000, 16'h0012);
      repeat (3) @(negedge clk);
      compare("interrupt with ie clear", 18'(int_count - ic), 18'd0);
      end_test("interrupt", e0);

      e0 = errors;
      inject_err = 1'b1;
      run_cmd(RK_FN_READ, 1'b0, 16'hff00, 16'h6000, 16'h0012);
      reg_read(RK_ADDR_CS, v, d);
      compare("err bit", 18'(v[CSR_ERR]), 18'd1);
      reg_write(RK_ADDR_CS, 16'd0);
      reg_read(RK_ADDR_CS, v, d);
      compare("err bit after clear", 18'(v[CSR_ERR]), 18'd0);
      inject_err = 1'b0;
      end_test("drive error", e0);

      $display("%0d tests run, %0d checks failed", tests, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// ==== run.sh ====
#!/bin/bash
# build and run the rk11 ide testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rk_ide -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "tests failed" sim.log; then
   exit 1
fi
exit 0

// ==== src/ata_pio.sv ====
/*
 * ide pio timing engine
 * one strobed task file access per request, with setup and release cycles
 */
`timescale 1ns/1ns

module ata_pio (
   input  logic             clk,
   input  logic             reset,
   input  rk_pkg::ata_req_t ata_req,
   output logic             ata_done,
   output logic [15:0]      ata_rdata,
   output rk_pkg::ide_out_t ide_out,
   input  logic [15:0]      ide_data_in
);
   import rk_pkg::*;

   logic [ATA_PHASE_W-1:0] phase;
   logic                   active;
   logic                   strobe;

   assign active = ata_req.rd || ata_req.wr;
   // phase 0 is address setup, the last phase releases the strobe
   assign strobe = (phase != '0) && (phase != ATA_PHASE_DONE);
   assign ata_done = phase == ATA_PHASE_DONE;

   always_ff @(posedge clk)
   begin
      if (reset)
         phase <= '0;
      else if (phase == ATA_PHASE_DONE)
         phase <= '0;
      else if (phase != '0 || active)
         phase <= phase + 1'b1;
   end

   // sample on the last strobe cycle, held until the next read
   always_ff @(posedge clk)
   begin
      if (ata_req.rd && phase == ATA_PHASE_SAMPLE)
         ata_rdata <= ide_data_in;
   end

   always_comb
   begin
      ide_out.dior = ata_req.rd && strobe;
      ide_out.diow = ata_req.wr && strobe;
      ide_out.cs = ata_req.addr[4:3];
      ide_out.da = ata_req.addr[2:0];
      ide_out.data = ata_req.wdata;
      // bus driven only while writing
      ide_out.data_oe = ata_req.wr && strobe;
   end

endmodule

// ==== src/rk_ide_top.sv ====
/*
 * rk11 controller on an ide drive
 * register file, command sequencer and pio engine
 */
`timescale 1ns/1ns

module rk_ide_top (
   input  logic                clk,
   input  logic                reset,
   input  rk_pkg::iopage_req_t iopage,
   output logic [15:0]         data_out,
   output logic                decode,
   output logic                interrupt,
   input  logic                interrupt_ack,
   output rk_pkg::dma_out_t    dma,
   input  logic                dma_ack,
   input  logic [15:0]         dma_data_in,
   output rk_pkg::ide_out_t    ide_out,
   input  logic [15:0]         ide_data_in
);
   import rk_pkg::*;

   rk_ctl_t     ctl;
   rk_event_t   ev;
   ata_req_t    ata_req;
   logic        ata_done;
   logic [15:0] ata_rdata;

   rk_regs i_regs (
      .clk(clk), .reset(reset), .iopage(iopage), .data_out(data_out),
      .decode(decode), .ctl(ctl), .ev(ev), .interrupt(interrupt),
      .interrupt_ack(interrupt_ack)
   );

   rk_sequencer i_seq (
      .clk(clk), .reset(reset), .ctl(ctl), .ev(ev), .ata_req(ata_req),
      .ata_done(ata_done), .ata_rdata(ata_rdata), .dma(dma), .dma_ack(dma_ack),
      .dma_data_in(dma_data_in)
   );

   ata_pio i_pio (
      .clk(clk), .reset(reset), .ata_req(ata_req), .ata_done(ata_done),
      .ata_rdata(ata_rdata), .ide_out(ide_out), .ide_data_in(ide_data_in)
   );

endmodule

// ==== src/rk_pkg.sv ====
/*
 * rk11 over ide shared definitions
 * register offsets, csr bits, ata task file codes and the structs between blocks
 */
package rk_pkg;

   // i/o page offsets of the rk11 registers
   localparam logic [12:0] RK_ADDR_DS = 13'o17400;
   localparam logic [12:0] RK_ADDR_ER = 13'o17402;
   localparam logic [12:0] RK_ADDR_CS = 13'o17404;
   localparam logic [12:0] RK_ADDR_WC = 13'o17406;
   localparam logic [12:0] RK_ADDR_BA = 13'o17410;
   localparam logic [12:0] RK_ADDR_DA = 13'o17412;

   localparam logic [7:0] RK_VECTOR = 8'o220;

   // rkcs bit positions
   localparam int CSR_GO   = 0;
   localparam int CSR_FN   = 1;
   localparam int CSR_MEX  = 4;
   localparam int CSR_IE   = 6;
   localparam int CSR_DONE = 7;
   localparam int CSR_ERR  = 15;

   localparam logic [2:0] RK_FN_WRITE = 3'd1;
   localparam logic [2:0] RK_FN_READ  = 3'd2;

   // ata registers as {cs, da}
   localparam logic [4:0] ATA_REG_ALTER   = 5'b01110;
   localparam logic [4:0] ATA_REG_DEVCTRL = 5'b01110;
   localparam logic [4:0] ATA_REG_DATA    = 5'b10000;
   localparam logic [4:0] ATA_REG_ERROR   = 5'b10001;
   localparam logic [4:0] ATA_REG_SECCNT  = 5'b10010;
   localparam logic [4:0] ATA_REG_SECNUM  = 5'b10011;
   localparam logic [4:0] ATA_REG_CYLLOW  = 5'b10100;
   localparam logic [4:0] ATA_REG_CYLHIGH = 5'b10101;
   localparam logic [4:0] ATA_REG_DRVHEAD = 5'b10110;
   localparam logic [4:0] ATA_REG_STATUS  = 5'b10111;
   localparam logic [4:0] ATA_REG_COMMAND = 5'b10111;

   localparam int STAT_BSY  = 7;
   localparam int STAT_DRDY = 6;
   localparam int STAT_DRQ  = 3;
   localparam int STAT_ERR  = 0;

   localparam logic [15:0] ATA_CMD_READ     = 16'h0020;
   localparam logic [15:0] ATA_CMD_WRITE    = 16'h0030;
   localparam logic [15:0] ATA_DRVHEAD_LBA  = 16'h0040;
   localparam logic [15:0] ATA_DEVCTRL_NIEN = 16'h0002;

   // pio access timing: setup, strobe, strobe, release
   localparam int ATA_CYCLES  = 4;
   localparam int ATA_PHASE_W = $clog2(ATA_CYCLES);
   localparam logic [ATA_PHASE_W-1:0] ATA_PHASE_SAMPLE = ATA_PHASE_W'(ATA_CYCLES - 2);
   localparam logic [ATA_PHASE_W-1:0] ATA_PHASE_DONE   = ATA_PHASE_W'(ATA_CYCLES - 1);

   typedef struct packed {
      logic [12:0] addr;
      logic [15:0] data;
      logic        rd;
      logic        wr;
      logic        byte_op;
   } iopage_req_t;

   typedef struct packed {
      logic [2:0]  fn;
      logic        go;
      logic        ie;
      logic [15:0] wc;
      logic [17:0] ba;
      logic [15:0] da;
   } rk_ctl_t;

   typedef struct packed {
      logic set_err;
      logic set_done;
      logic clear_cmd;
      logic inc_ba;
      logic inc_wc;
      logic assert_int;
   } rk_event_t;

   typedef struct packed {
      logic        rd;
      logic        wr;
      logic [4:0]  addr;
      logic [15:0] wdata;
   } ata_req_t;

   typedef struct packed {
      logic        dior;
      logic        diow;
      logic [1:0]  cs;
      logic [2:0]  da;
      logic [15:0] data;
      logic        data_oe;
   } ide_out_t;

   typedef struct packed {
      logic        req;
      logic        rd;
      logic        wr;
      logic [17:0] addr;
      logic [15:0] wdata;
   } dma_out_t;

endpackage

// ==== src/rk_regs.sv ====
/*
 * rk11 host register file
 * decodes the i/o page, applies sequencer events and keeps the interrupt flag
 */
`timescale 1ns/1ns

module rk_regs (
   input  logic                clk,
   input  logic                reset,
   input  rk_pkg::iopage_req_t iopage,
   output logic [15:0]         data_out,
   output logic                decode,
   output rk_pkg::rk_ctl_t     ctl,
   input  rk_pkg::rk_event_t   ev,
   output logic                interrupt,
   input  logic                interrupt_ack
);
   import rk_pkg::*;

   rk_ctl_t     regs;
   logic        done;
   logic        err;
   logic        host_wr;
   logic [15:0] csr;

   assign ctl = regs;
   assign host_wr = iopage.wr && decode;
   assign csr = {err, 7'd0, done, regs.ie, regs.ba[17:16], regs.fn, regs.go};

   // read mux, unmapped offsets give zero
   always_comb
   begin
      decode = 1'b1;
      case (iopage.addr)
         RK_ADDR_DS: data_out = 16'd0;
         // drive error mirrors the csr error bit
         RK_ADDR_ER: data_out = {err, 15'd0};
         RK_ADDR_CS: data_out = csr;
         RK_ADDR_WC: data_out = regs.wc;
         RK_ADDR_BA: data_out = regs.ba[15:0];
         RK_ADDR_DA: data_out = regs.da;
         default:
         begin
            decode = 1'b0;
            data_out = 16'd0;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         regs <= '0;
         done <= 1'b0;
         err <= 1'b0;
      end
      else if (host_wr)
      begin
         case (iopage.addr)
            RK_ADDR_CS:
            begin
               err <= 1'b0;
               done <= iopage.data[CSR_DONE];
               regs.ie <= iopage.data[CSR_IE];
               regs.ba[17:16] <= iopage.data[CSR_MEX +: 2];
               regs.fn <= iopage.data[CSR_FN +: 3];
               regs.go <= iopage.data[CSR_GO];
            end
            RK_ADDR_WC: regs.wc <= iopage.data;
            RK_ADDR_BA: regs.ba[15:0] <= iopage.data;
            RK_ADDR_DA: regs.da <= iopage.data;
            default: ;
         endcase
      end
      else
      begin
         if (ev.set_err)
            err <= 1'b1;
         if (ev.set_done)
            done <= 1'b1;
         if (ev.clear_cmd)
         begin
            regs.fn <= '0;
            regs.go <= 1'b0;
         end
         // word address, so two bytes per word
         if (ev.inc_ba)
            regs.ba <= regs.ba + 18'd2;
         // wc counts up towards zero
         if (ev.inc_wc)
            regs.wc <= regs.wc + 16'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         interrupt <= 1'b0;
      else if (ev.assert_int)
         interrupt <= 1'b1;
      else if (interrupt_ack)
         interrupt <= 1'b0;
   end

endmodule

// ==== src/rk_sequencer.sv ====
/*
 * rk11 command sequencer
 * loads the ata task file, moves words between drive and memory, signals completion
 */
`timescale 1ns/1ns

module rk_sequencer (
   input  logic              clk,
   input  logic              reset,
   input  rk_pkg::rk_ctl_t   ctl,
   output rk_pkg::rk_event_t ev,
   output rk_pkg::ata_req_t  ata_req,
   input  logic              ata_done,
   input  logic [15:0]       ata_rdata,
   output rk_pkg::dma_out_t  dma,
   input  logic              dma_ack,
   input  logic [15:0]       dma_data_in
);
   import rk_pkg::*;

   typedef enum logic [4:0] {
      ST_IDLE, ST_RDY0, ST_DRVHEAD0, ST_RDY1, ST_DEVCTRL, ST_SECCNT, ST_SECNUM,
      ST_CYLLOW, ST_CYLHIGH, ST_DRVHEAD1, ST_COMMAND, ST_ALTER, ST_DRQ,
      ST_ATA_RD, ST_DMA_WR, ST_DMA_RD, ST_ATA_WR,
      ST_LAST_ALT, ST_LAST_STAT, ST_LAST_DONE, ST_LAST_INT
   } state_t;

   state_t      state;
   state_t      state_next;
   state_t      after_word;
   ata_req_t    req;
   logic        gap;
   logic        is_write;
   logic        fn_ok;
   logic        drive_ready;
   logic        drive_drq;
   logic [15:0] lba;
   logic [15:0] wc_next;
   logic [15:0] wbuf;
   logic [7:0]  seccnt;

   // lba is track * 12 + sector
   assign lba = 16'(ctl.da[13:4]) * 16'd12 + 16'(ctl.da[3:0]);
   assign seccnt = 8'd0 - ctl.wc[15:8];
   assign wc_next = ctl.wc + 16'd1;
   assign is_write = ctl.fn == RK_FN_WRITE;
   assign fn_ok = is_write || ctl.fn == RK_FN_READ;
   assign drive_ready = !ata_rdata[STAT_BSY] && ata_rdata[STAT_DRDY];
   assign drive_drq = !ata_rdata[STAT_BSY] && ata_rdata[STAT_DRQ];

   // where to go once a word is through, a new sector needs drq again
   always_comb
   begin
      if (wc_next == 16'd0)
         after_word = ST_LAST_ALT;
      else if (wc_next[7:0] == 8'd0)
         after_word = ST_ALTER;
      else if (is_write)
         after_word = ST_DMA_RD;
      else
         after_word = ST_ATA_RD;
   end

   // ata access per state
   always_comb
   begin
      case (state)
         ST_RDY0, ST_RDY1, ST_DRQ, ST_LAST_STAT:
            req = '{rd: 1'b1, wr: 1'b0, addr: ATA_REG_STATUS, wdata: 16'd0};
         ST_ALTER, ST_LAST_ALT:
            req = '{rd: 1'b1, wr: 1'b0, addr: ATA_REG_ALTER, wdata: 16'd0};
         ST_ATA_RD:
            req = '{rd: 1'b1, wr: 1'b0, addr: ATA_REG_DATA, wdata: 16'd0};
         ST_DRVHEAD0, ST_DRVHEAD1:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_DRVHEAD, wdata: ATA_DRVHEAD_LBA};
         ST_DEVCTRL:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_DEVCTRL, wdata: ATA_DEVCTRL_NIEN};
         ST_SECCNT:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_SECCNT, wdata: {8'd0, seccnt}};
         ST_SECNUM:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_SECNUM, wdata: {8'd0, lba[7:0]}};
         ST_CYLLOW:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_CYLLOW, wdata: {8'd0, lba[15:8]}};
         ST_CYLHIGH:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_CYLHIGH, wdata: 16'd0};
         ST_COMMAND:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_COMMAND,
                    wdata: is_write ? ATA_CMD_WRITE : ATA_CMD_READ};
         ST_ATA_WR:
            req = '{rd: 1'b0, wr: 1'b1, addr: ATA_REG_DATA, wdata: wbuf};
         default:
            req = '0;
      endcase
   end

   // request drops for one cycle after each done so the access is not repeated
   always_comb
   begin
      ata_req = req;
      ata_req.rd = req.rd && !gap;
      ata_req.wr = req.wr && !gap;
   end

   always_comb
   begin
      state_next = state;
      ev = '0;
      dma = '0;
      dma.addr = ctl.ba;
      dma.wdata = ata_rdata;
      case (state)
         ST_IDLE:
            if (ctl.go)
               state_next = fn_ok ? ST_RDY0 : ST_LAST_DONE;
         ST_RDY0:
            if (ata_done && drive_ready)
               state_next = ST_DRVHEAD0;
         ST_DRVHEAD0:
            if (ata_done)
               state_next = ST_RDY1;
         ST_RDY1:
            if (ata_done && drive_ready)
               state_next = ST_DEVCTRL;
         ST_DEVCTRL:
            if (ata_done)
               state_next = ST_SECCNT;
         ST_SECCNT:
            if (ata_done)
               state_next = ST_SECNUM;
         ST_SECNUM:
            if (ata_done)
               state_next = ST_CYLLOW;
         ST_CYLLOW:
            if (ata_done)
               state_next = ST_CYLHIGH;
         ST_CYLHIGH:
            if (ata_done)
               state_next = ST_DRVHEAD1;
         ST_DRVHEAD1:
            if (ata_done)
               state_next = ST_COMMAND;
         ST_COMMAND:
            if (ata_done)
               state_next = ST_ALTER;
         ST_ALTER:
            if (ata_done)
               state_next = ST_DRQ;
         ST_DRQ:
            if (ata_done)
            begin
               // a drive error ends the command early
               ev.set_err = ata_rdata[STAT_ERR];
               if (ata_rdata[STAT_ERR])
                  state_next = ST_LAST_ALT;
               else if (drive_drq)
                  state_next = is_write ? ST_DMA_RD : ST_ATA_RD;
            end
         ST_ATA_RD:
            if (ata_done)
               state_next = ST_DMA_WR;
         ST_DMA_WR:
         begin
            dma.req = 1'b1;
            if (dma_ack)
            begin
               dma.wr = 1'b1;
               ev.inc_wc = 1'b1;
               ev.inc_ba = 1'b1;
               state_next = after_word;
            end
         end
         ST_DMA_RD:
         begin
            dma.req = 1'b1;
            if (dma_ack)
            begin
               dma.rd = 1'b1;
               state_next = ST_ATA_WR;
            end
         end
         ST_ATA_WR:
            if (ata_done)
            begin
               ev.inc_wc = 1'b1;
               ev.inc_ba = 1'b1;
               state_next = after_word;
            end
         ST_LAST_ALT:
            if (ata_done)
               state_next = ST_LAST_STAT;
         ST_LAST_STAT:
            if (ata_done)
               state_next = ST_LAST_DONE;
         ST_LAST_DONE:
         begin
            ev.set_done = 1'b1;
            ev.clear_cmd = 1'b1;
            ev.assert_int = ctl.ie;
            state_next = ST_LAST_INT;
         end
         ST_LAST_INT:
         begin
            ev.assert_int = ctl.ie;
            state_next = ST_IDLE;
         end
         default:
            state_next = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         gap <= 1'b0;
      end
      else
      begin
         state <= state_next;
         gap <= ata_done;
      end
   end

   // memory word waiting to go out to the ata data register
   always_ff @(posedge clk)
   begin
      if (state == ST_DMA_RD && dma_ack)
         wbuf <= dma_data_in;
   end

endmodule
